/* bench/rv_core_golden.txt */
// header: program length, irq cycle, preload address, preload data, store count
// then program words, then store records as address, data, ls_type
47 12C 1100 F0E1D2C3B4A59687 18
00001537 06400093 FF900113 002081B3 00353023 40110233 00453423 02809293
00553823 40115313 001123B3 00113433 0020C4B3 00652C23 02750023 02951123
02853423 00001597 02B53823 10053603 10050683 10154703 10251783 10055803
10452883 10056903 02C53C23 04D53023 04E53423 04F53823 05053C23 07153023
07253423 00000997 09098993 30599A73 05500A93 340A9B73 34001BF3 07453823
07753C23 00300C13 00000C93 018C8CB3 FFFC0C13 FE0C1CE3 09953023 00C000EF
00053023 00053023 08153423 00000463 00053023 00000D97 00CD8D67 00053023
09A53823 00114463 00053023 00116463 08753C23 0020D463 00053023 0020F463
0A253023 000E8063 0BD53423 0B552823 0000006F 34201EF3 30200073
1000 5D 3
1008 FFFFFFFFFFFFFF95 3
1010 0000640000000000 3
1018 00000000FFFFFFFC 2
1020 1 0
1022 FF9D 1
1028 0 3
1030 80001044 3
1038 F0E1D2C3B4A59687 3
1040 FFFFFFFFFFFFFF87 3
1048 96 3
1050 FFFFFFFFFFFFB4A5 3
1058 9687 3
1060 FFFFFFFFF0E1D2C3 3
1068 B4A59687 3
1070 0 3
1078 55 3
1080 6 3
1088 800000C0 3
1090 800000DC 3
1098 1 3
10A0 FFFFFFFFFFFFFFF9 3
10A8 800000000000000B 3
10B0 55 2

/* build.f */
+incdir+common
common/rv_core_pkg.sv
core/rv_decode.sv
core/rv_alu.sv
core/rv_regfile.sv
core/rv_csr_file.sv
core/rv_exec_ctrl.sv
verilog/rv_core_top.sv
bench/tb_clock_gen.sv
bench/rv_core_asserts.sv
bench/rv_core_tb.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = rv_core_tb
FILELIST = build.f
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* bench/rv_core_tb.sv */
`include "rv_core_settings.svh"

module rv_core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int GOLD_DEPTH = 512;
    localparam int HDR = 5;             // words before the program

    logic clk;
    logic reset;
    rv_core_pkg::inst_t    instruction;
    logic                  irq;
    logic                  rd_done;
    logic                  wr_done;
    rv_core_pkg::xword_t   rd_data;
    rv_core_pkg::pc_t      pc;
    rv_core_pkg::inst_t    ir;
    rv_core_pkg::bus_req_t bus;
    logic                  int_ack;

    logic [63:0]        golden [0:GOLD_DEPTH-1];
    rv_core_pkg::inst_t rom [0:255];
    logic [7:0]         dmem [longint];     // sparse byte memory
    logic [39:0]        rom_off;
    int prog_len, irq_cycle, store_cnt, rec_base, limit;
    int cycle, rec_idx, errors, ack_cnt, wait_cnt;
    integer seed;
    logic pend_rd, pend_wr;
    rv_core_pkg::bus_addr_t pend_addr;

    tb_clock_gen i_clk_gen (
        .clk_o   (clk),
        .reset_o (reset)
    );

    rv_core_top i_dut (
        .clk           (clk),
        .reset         (reset),
        .instruction_i (instruction),
        .irq_i         (irq),
        .rd_done_i     (rd_done),
        .wr_done_i     (wr_done),
        .rd_data_i     (rd_data),
        .pc_o          (pc),
        .ir_o          (ir),
        .bus_o         (bus),
        .int_ack_o     (int_ack)
    );

    // program rom answers in the same cycle, nop outside the program
    always_comb begin
        rom_off = (pc - `RESET_PC) >> 2;
        if (rom_off < 40'(prog_len)) instruction = rom[rom_off[7:0]];
        else instruction = `NOP_WORD;
    end

    // unwritten bytes get a pattern of the whole address
    function automatic logic [7:0] mem_byte(input longint a);
        logic [38:0] x;
        x = a[38:0];
        if (dmem.exists(a)) return dmem[a];
        return x[7:0] ^ x[15:8] ^ x[23:16] ^ x[31:24] ^ {1'b0, x[38:32]};
    endfunction

    function automatic rv_core_pkg::xword_t read_dword(input longint a);
        rv_core_pkg::xword_t v;
        for (int i = 0; i < 8; i++) v[8*i +: 8] = mem_byte(a + longint'(i));
        return v;
    endfunction

    task automatic write_bytes(input longint a, input rv_core_pkg::xword_t d,
                               input rv_core_pkg::ls_type_t t);
        int n;
        n = 1 << t[1:0];            // 1, 2, 4 or 8 bytes
        for (int i = 0; i < n; i++) dmem[a + longint'(i)] = d[8*i +: 8];
    endtask

    task automatic check_store(input rv_core_pkg::bus_req_t r);
        int b;
        if (rec_idx >= store_cnt) begin
            $display("unexpected extra store to address %h", r.addr);
            errors++;
        end else begin
            b = rec_base + 3 * rec_idx;
            if (r.addr !== golden[b][`ADDR_W-1:0]) begin
                $display("Fail bus_o.addr record %0d expected %h got %h",
                         rec_idx, golden[b][`ADDR_W-1:0], r.addr);
                errors++;
            end
            if (r.wdata !== golden[b+1]) begin
                $display("Fail bus_o.wdata record %0d expected %h got %h",
                         rec_idx, golden[b+1], r.wdata);
                errors++;
            end
            if (r.ls_type !== golden[b+2][2:0]) begin
                $display("Fail bus_o.ls_type record %0d expected %h got %h",
                         rec_idx, golden[b+2][2:0], r.ls_type);
                errors++;
            end
            rec_idx++;
        end
    endtask

    // fetch state and strobes straight out of reset
    task automatic compare_reset_values();
        if (pc !== `RESET_PC) begin
            $display("Fail pc_o after reset expected %h got %h", `RESET_PC, pc);
            errors++;
        end
        if (ir !== `NOP_WORD) begin
            $display("Fail ir_o after reset expected %h got %h", `NOP_WORD, ir);
            errors++;
        end
        if (bus.rd_en !== 1'b0 || bus.wr_en !== 1'b0 || int_ack !== 1'b0) begin
            $display("bus enable or interrupt acknowledge high right after reset");
            errors++;
        end
    endtask

    // bus outputs are settled mid cycle
    always @(negedge clk) begin
        if (reset && (bus.rd_en || bus.wr_en)) begin
            if (pend_rd || pend_wr) begin
                $display("new bus request while the previous one is still open");
                errors++;
            end
            wait_cnt  = ($random(seed) & 3) + 1;    // 1..4 cycles
            pend_addr = bus.addr;
            pend_rd   = bus.rd_en;
            pend_wr   = bus.wr_en;
            if (bus.wr_en) begin
                check_store(bus);
                write_bytes(longint'(bus.addr), bus.wdata, bus.ls_type);
            end
        end
    end

    always @(posedge clk) begin
        #2;
        cycle++;
        rd_done = 1'b0;
        wr_done = 1'b0;
        if (int_ack) begin
            ack_cnt++;
            irq = 1'b0;                 // drop once taken
        end
        if (cycle == irq_cycle) irq = 1'b1;
        if (pend_rd || pend_wr) begin
            wait_cnt--;
            if (wait_cnt == 0) begin
                if (pend_rd) begin
                    rd_done = 1'b1;
                    rd_data = read_dword(longint'(pend_addr));
                end else begin
                    wr_done = 1'b1;
                end
                pend_rd = 1'b0;
                pend_wr = 1'b0;
            end
        end
    end

    initial begin
        seed      = 35;
        irq       = 1'b0;
        rd_done   = 1'b0;
        wr_done   = 1'b0;
        rd_data   = '0;
        pend_rd   = 1'b0;
        pend_wr   = 1'b0;
        pend_addr = '0;
        wait_cnt  = 0;
        cycle     = 0;
        rec_idx   = 0;
        errors    = 0;
        ack_cnt   = 0;
        prog_len  = 0;
        $readmemh("bench/rv_core_golden.txt", golden);
        prog_len  = int'(golden[0]);
        irq_cycle = int'(golden[1]);
        write_bytes(longint'(golden[2]), golden[3], 3'd3);  // preloaded dword
        store_cnt = int'(golden[4]);
        for (int i = 0; i < prog_len; i++) rom[i] = golden[HDR+i][31:0];
        rec_base  = HDR + prog_len;
        limit     = 40 * prog_len + 500;

        @(posedge reset);
        @(negedge clk);                 // first cycle out of reset
        compare_reset_values();

        while (rec_idx < store_cnt && cycle < limit) @(posedge clk);
        if (rec_idx < store_cnt) begin
            $display("timeout after %0d cycles, only %0d of %0d stores seen",
                     cycle, rec_idx, store_cnt);
            errors++;
        end
        repeat (20) @(posedge clk);     // catch stray stores
        if (ack_cnt != 1) begin
            $display("interrupt acknowledge pulsed %0d times instead of once", ack_cnt);
            errors++;
        end
        $display("errors %0d, stores checked %0d of %0d, acks %0d, cycles %0d",
                 errors, rec_idx, store_cnt, ack_cnt, cycle);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* bench/rv_core_asserts.sv */
module rv_core_asserts (
    input logic                  clk,
    input logic                  reset,
    input rv_core_pkg::bus_req_t bus_i,
    input logic                  int_ack_i,
    input logic                  rd_done_i,
    input logic                  wr_done_i
);
    timeunit 1ns;
    timeprecision 100ps;

    logic outstanding;      // request issued, done not yet seen

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            outstanding <= 1'b0;
        end else if (bus_i.rd_en || bus_i.wr_en) begin
            outstanding <= 1'b1;
        end else if (rd_done_i || wr_done_i) begin
            outstanding <= 1'b0;
        end
    end

    a_one_enable: assert property (@(posedge clk) disable iff (!reset)
        !(bus_i.rd_en && bus_i.wr_en))
        else $error("rd_en and wr_en high in the same cycle");

    a_ack_pulse: assert property (@(posedge clk) disable iff (!reset)
        int_ack_i |=> !int_ack_i)
        else $error("int_ack_o high for two cycles in a row");

    a_no_overlap: assert property (@(posedge clk) disable iff (!reset)
        (bus_i.rd_en || bus_i.wr_en) |-> !outstanding)
        else $error("bus request before the done of the previous one");

endmodule

bind rv_core_top rv_core_asserts i_asserts (
    .clk       (clk),
    .reset     (reset),
    .bus_i     (bus_o),
    .int_ack_i (int_ack_o),
    .rd_done_i (rd_done_i),
    .wr_done_i (wr_done_i)
);

/* bench/tb_clock_gen.sv */
module tb_clock_gen #(
    parameter int PERIOD = 40,          // ns
    parameter int RESET_CYCLES = 16
) (
    output logic clk_o,
    output logic reset_o
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD / 2) clk_o = ~clk_o;
    end

    // active low, released just after an edge
    initial begin
        reset_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #2 reset_o = 1'b1;
    end

endmodule

/* verilog/rv_core_top.sv */
module rv_core_top (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::inst_t    instruction_i,
    input  logic                  irq_i,
    input  logic                  rd_done_i,
    input  logic                  wr_done_i,
    input  rv_core_pkg::xword_t   rd_data_i,
    output rv_core_pkg::pc_t      pc_o,
    output rv_core_pkg::inst_t    ir_o,
    output rv_core_pkg::bus_req_t bus_o,
    output logic                  int_ack_o
);

    rv_core_pkg::decoded_t dec;
    rv_core_pkg::alu_res_t alu_res;
    rv_core_pkg::xword_t   rs1, rs2;
    rv_core_pkg::reg_idx_t rd_idx;
    rv_core_pkg::xword_t   rd_data;
    rv_core_pkg::xword_t   csr_rdata, mtvec, mepc;
    logic rd_we, csr_we, irq_take, mret, mie;

    rv_decode i_decode (
        .ir_i  (ir_o),
        .dec_o (dec)
    );

    rv_alu i_alu (
        .dec_i (dec),
        .rs1_i (rs1),
        .rs2_i (rs2),
        .pc_i  (pc_o),
        .res_o (alu_res)
    );

    rv_regfile i_regfile (
        .clk       (clk),
        .reset     (reset),
        .rs1_idx_i (dec.rs1),
        .rs2_idx_i (dec.rs2),
        .rd_idx_i  (rd_idx),
        .rd_we_i   (rd_we),
        .rd_data_i (rd_data),
        .rs1_o     (rs1),
        .rs2_o     (rs2)
    );

    // csrrw source is rs1, epc taken from the fetch pc
    rv_csr_file i_csr_file (
        .clk         (clk),
        .reset       (reset),
        .csr_addr_i  (dec.csr),
        .csr_we_i    (csr_we),
        .csr_wdata_i (rs1),
        .irq_take_i  (irq_take),
        .mret_i      (mret),
        .epc_i       (pc_o),
        .csr_rdata_o (csr_rdata),
        .mtvec_o     (mtvec),
        .mepc_o      (mepc),
        .mie_o       (mie)
    );

    rv_exec_ctrl i_exec_ctrl (
        .clk           (clk),
        .reset         (reset),
        .instruction_i (instruction_i),
        .dec_i         (dec),
        .alu_i         (alu_res),
        .rs2_i         (rs2),
        .csr_rdata_i   (csr_rdata),
        .mtvec_i       (mtvec),
        .mepc_i        (mepc),
        .mie_i         (mie),
        .irq_i         (irq_i),
        .rd_done_i     (rd_done_i),
        .wr_done_i     (wr_done_i),
        .rd_data_i     (rd_data_i),
        .pc_o          (pc_o),
        .ir_o          (ir_o),
        .bus_o         (bus_o),
        .rd_idx_o      (rd_idx),
        .rd_we_o       (rd_we),
        .rd_data_o     (rd_data),
        .csr_we_o      (csr_we),
        .irq_take_o    (irq_take),
        .mret_o        (mret),
        .int_ack_o     (int_ack_o)
    );

endmodule

/* core/rv_exec_ctrl.sv */
`include "rv_core_settings.svh"

module rv_exec_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::inst_t     instruction_i,   // word at pc_o, same cycle
    input  rv_core_pkg::decoded_t  dec_i,
    input  rv_core_pkg::alu_res_t  alu_i,
    input  rv_core_pkg::xword_t    rs2_i,
    input  rv_core_pkg::xword_t    csr_rdata_i,
    input  rv_core_pkg::xword_t    mtvec_i,
    input  rv_core_pkg::xword_t    mepc_i,
    input  logic                   mie_i,
    input  logic                   irq_i,
    input  logic                   rd_done_i,
    input  logic                   wr_done_i,
    input  rv_core_pkg::xword_t    rd_data_i,
    output rv_core_pkg::pc_t       pc_o,
    output rv_core_pkg::inst_t     ir_o,
    output rv_core_pkg::bus_req_t  bus_o,
    output rv_core_pkg::reg_idx_t  rd_idx_o,
    output logic                   rd_we_o,
    output rv_core_pkg::xword_t    rd_data_o,
    output logic                   csr_we_o,
    output logic                   irq_take_o,
    output logic                   mret_o,
    output logic                   int_ack_o
);

    localparam rv_core_pkg::csr_addr_t mret_f12 = 12'h302;

    rv_core_pkg::pc_t         pc_q;
    rv_core_pkg::pc_t         pc_d;
    rv_core_pkg::inst_t       ir_q;
    rv_core_pkg::ctrl_state_t state_q;
    rv_core_pkg::ctrl_state_t state_d;
    rv_core_pkg::xword_t      load_ext;
    rv_core_pkg::xword_t      st_data;
    logic bubble_q;     // ir holds a flushed slot, nothing to interrupt
    logic int_ack_q;
    logic exec;         // ir executes this cycle
    logic is_load, is_store, is_csrrw;
    logic jump, redirect, hold;

    assign is_load  = (dec_i.opcode == `OP_LOAD);
    assign is_store = (dec_i.opcode == `OP_STORE);
    assign is_csrrw = (dec_i.opcode == `OP_SYSTEM) && (dec_i.funct3 == 3'b001);

    // interrupt only between real instructions, ir is then dropped
    assign irq_take_o = (state_q == rv_core_pkg::RUN) && !bubble_q && irq_i && mie_i;
    assign exec       = (state_q == rv_core_pkg::RUN) && !irq_take_o;
    assign mret_o     = exec && (dec_i.opcode == `OP_SYSTEM) && (dec_i.funct3 == 3'b000)
                        && (dec_i.csr == mret_f12);
    assign csr_we_o   = exec && is_csrrw;
    assign jump       = exec && alu_i.taken;          // taken branch, jal, jalr
    assign redirect   = irq_take_o || mret_o || jump;

    // freeze pc and ir from bus issue until the done pulse
    assign hold = (exec && (is_load || is_store))
                || ((state_q == rv_core_pkg::LOAD_WAIT) && !rd_done_i)
                || ((state_q == rv_core_pkg::STORE_WAIT) && !wr_done_i);

    always_comb begin
        pc_d = pc_q + rv_core_pkg::pc_t'(4);
        if (irq_take_o) pc_d = mtvec_i[`PC_W-1:0];
        else if (mret_o) pc_d = mepc_i[`PC_W-1:0];   // back to the skipped word
        else if (jump)   pc_d = alu_i.result[`PC_W-1:0];

        state_d = state_q;
        case (state_q)
            rv_core_pkg::RUN: begin
                if (exec && is_load) state_d = rv_core_pkg::LOAD_WAIT;
                else if (exec && is_store) state_d = rv_core_pkg::STORE_WAIT;
            end
            rv_core_pkg::LOAD_WAIT:  if (rd_done_i) state_d = rv_core_pkg::RUN;
            rv_core_pkg::STORE_WAIT: if (wr_done_i) state_d = rv_core_pkg::RUN;
            default: state_d = rv_core_pkg::RUN;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            pc_q      <= `RESET_PC;
            ir_q      <= `NOP_WORD;
            bubble_q  <= 1'b1;           // first ir is the reset nop
            state_q   <= rv_core_pkg::RUN;
            int_ack_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            int_ack_q <= irq_take_o;     // high while pc holds mtvec
            bubble_q  <= redirect;
            if (redirect) begin
                pc_q <= pc_d;
                ir_q <= `NOP_WORD;        // flush the wrong-path word
            end else if (!hold) begin
                pc_q <= pc_d;
                ir_q <= instruction_i;
            end
        end
    end

    // load data extension per funct3
    always_comb begin
        case (dec_i.funct3)
            3'b000:  load_ext = {{(`XLEN-8){rd_data_i[7]}}, rd_data_i[7:0]};     // lb
            3'b001:  load_ext = {{(`XLEN-16){rd_data_i[15]}}, rd_data_i[15:0]};  // lh
            3'b010:  load_ext = {{(`XLEN-32){rd_data_i[31]}}, rd_data_i[31:0]};  // lw
            3'b100:  load_ext = rv_core_pkg::xword_t'(rd_data_i[7:0]);
            3'b101:  load_ext = rv_core_pkg::xword_t'(rd_data_i[15:0]);
            3'b110:  load_ext = rv_core_pkg::xword_t'(rd_data_i[31:0]);
            default: load_ext = rd_data_i;                                       // ld
        endcase

        case (dec_i.funct3[1:0])
            2'b00:   st_data = rv_core_pkg::xword_t'(rs2_i[7:0]);
            2'b01:   st_data = rv_core_pkg::xword_t'(rs2_i[15:0]);
            2'b10:   st_data = rv_core_pkg::xword_t'(rs2_i[31:0]);
            default: st_data = rs2_i;
        endcase
    end

    // one-cycle request in the execute cycle
    always_comb begin
        bus_o.addr    = alu_i.mem_addr;
        bus_o.wdata   = st_data;
        bus_o.ls_type = dec_i.funct3;
        bus_o.rd_en   = exec && is_load;
        bus_o.wr_en   = exec && is_store;
    end

    // write-back source select
    always_comb begin
        rd_we_o   = 1'b0;
        rd_data_o = alu_i.result;
        if (state_q == rv_core_pkg::LOAD_WAIT) begin
            rd_we_o   = rd_done_i;
            rd_data_o = load_ext;
        end else if (exec) begin
            case (dec_i.opcode)
                `OP_OP, `OP_OPIMM, `OP_LUI, `OP_AUIPC: rd_we_o = 1'b1;
                `OP_JAL, `OP_JALR: begin
                    rd_we_o   = 1'b1;
                    rd_data_o = rv_core_pkg::xword_t'(pc_q);   // link, ir pc + 4
                end
                `OP_SYSTEM: begin
                    rd_we_o   = is_csrrw;
                    rd_data_o = csr_rdata_i;   // old csr value
                end
                default: ;
            endcase
        end
    end

    assign rd_idx_o  = dec_i.rd;
    assign pc_o      = pc_q;
    assign ir_o      = ir_q;
    assign int_ack_o = int_ack_q;

endmodule

/* core/rv_csr_file.sv */
`include "rv_core_settings.svh"

module rv_csr_file (
    input  logic                   clk,
    input  logic                   reset,
    input  rv_core_pkg::csr_addr_t csr_addr_i,
    input  logic                   csr_we_i,      // csrrw in execute
    input  rv_core_pkg::xword_t    csr_wdata_i,   // rs1
    input  logic                   irq_take_i,
    input  logic                   mret_i,
    input  rv_core_pkg::pc_t       epc_i,         // fetch pc at the interrupt
    output rv_core_pkg::xword_t    csr_rdata_o,
    output rv_core_pkg::xword_t    mtvec_o,
    output rv_core_pkg::xword_t    mepc_o,
    output logic                   mie_o
);

    rv_core_pkg::xword_t mstatus_q;
    rv_core_pkg::xword_t mtvec_q;
    rv_core_pkg::xword_t mscratch_q;
    rv_core_pkg::xword_t mepc_q;
    rv_core_pkg::xword_t mcause_q;

    // old value out, written at the same edge as rd
    always_comb begin
        case (csr_addr_i)
            `CSR_MSTATUS:  csr_rdata_o = mstatus_q;
            `CSR_MTVEC:    csr_rdata_o = mtvec_q;
            `CSR_MSCRATCH: csr_rdata_o = mscratch_q;
            `CSR_MEPC:     csr_rdata_o = mepc_q;
            `CSR_MCAUSE:   csr_rdata_o = mcause_q;
            default:       csr_rdata_o = '0;    // unknown csr reads zero
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            mstatus_q <= '0;
            mstatus_q[`MSTATUS_MIE] <= 1'b1;    // interrupts on out of reset
            mtvec_q    <= '0;
            mscratch_q <= '0;
            mepc_q     <= '0;
            mcause_q   <= '0;
        end else begin
            if (csr_we_i) begin
                case (csr_addr_i)
                    `CSR_MSTATUS:  mstatus_q  <= csr_wdata_i;
                    `CSR_MTVEC:    mtvec_q    <= csr_wdata_i;
                    `CSR_MSCRATCH: mscratch_q <= csr_wdata_i;
                    `CSR_MEPC:     mepc_q     <= csr_wdata_i;
                    `CSR_MCAUSE:   mcause_q   <= csr_wdata_i;
                    default: ;                  // write ignored
                endcase
            end
            if (irq_take_i) begin
                // epc_i runs one word ahead of the interrupted ir
                mepc_q   <= rv_core_pkg::xword_t'(epc_i - rv_core_pkg::pc_t'(4));
                mcause_q <= `MCAUSE_MEXT;
                mstatus_q[`MSTATUS_MPIE] <= mstatus_q[`MSTATUS_MIE];
                mstatus_q[`MSTATUS_MIE]  <= 1'b0;
            end else if (mret_i) begin
                mstatus_q[`MSTATUS_MIE]  <= mstatus_q[`MSTATUS_MPIE];
                mstatus_q[`MSTATUS_MPIE] <= 1'b1;
            end
        end
    end

    assign mtvec_o = mtvec_q;
    assign mepc_o  = mepc_q;
    assign mie_o   = mstatus_q[`MSTATUS_MIE];

endmodule

/* core/rv_regfile.sv */
`include "rv_core_settings.svh"

module rv_regfile (
    input  logic                  clk,
    input  logic                  reset,
    input  rv_core_pkg::reg_idx_t rs1_idx_i,
    input  rv_core_pkg::reg_idx_t rs2_idx_i,
    input  rv_core_pkg::reg_idx_t rd_idx_i,
    input  logic                  rd_we_i,
    input  rv_core_pkg::xword_t   rd_data_i,
    output rv_core_pkg::xword_t   rs1_o,
    output rv_core_pkg::xword_t   rs2_o
);

    rv_core_pkg::xword_t regs [1:(1<<`REG_AW)-1];   // no storage for x0

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int i = 1; i < (1 << `REG_AW); i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we_i && (rd_idx_i != '0)) begin
            regs[rd_idx_i] <= rd_data_i;     // writes to x0 dropped
        end
    end

    // combinational read ports, x0 reads zero
    assign rs1_o = (rs1_idx_i == '0) ? '0 : regs[rs1_idx_i];
    assign rs2_o = (rs2_idx_i == '0) ? '0 : regs[rs2_idx_i];

endmodule

/* core/rv_alu.sv */
`include "rv_core_settings.svh"

module rv_alu (
    input  rv_core_pkg::decoded_t dec_i,
    input  rv_core_pkg::xword_t   rs1_i,
    input  rv_core_pkg::xword_t   rs2_i,
    input  rv_core_pkg::pc_t      pc_i,     // fetch pc, one word past ir
    output rv_core_pkg::alu_res_t res_o
);

    rv_core_pkg::xword_t op_b;
    rv_core_pkg::xword_t ir_pc;      // address of the word in ir
    rv_core_pkg::xword_t arith;
    rv_core_pkg::xword_t addr_sum;
    logic signed [`XLEN-1:0] sra_val;
    logic [5:0] shamt;
    logic       cmp;
    logic       is_sub;

    always_comb begin
        op_b   = (dec_i.opcode == `OP_OP) ? rs2_i : dec_i.imm_i;
        shamt  = op_b[5:0];                  // rv64 shifts use 6 bits
        ir_pc  = rv_core_pkg::xword_t'(pc_i - rv_core_pkg::pc_t'(4));
        is_sub = (dec_i.opcode == `OP_OP) && dec_i.f7_bit;   // no subi
        sra_val = $signed(rs1_i) >>> shamt;  // own statement keeps it signed

        case (dec_i.funct3)
            3'b000: arith = is_sub ? rs1_i - op_b : rs1_i + op_b;
            3'b001: arith = rs1_i << shamt;
            3'b010: arith = rv_core_pkg::xword_t'($signed(rs1_i) < $signed(op_b));
            3'b011: arith = rv_core_pkg::xword_t'(rs1_i < op_b);   // sltu / sltiu
            3'b100: arith = rs1_i ^ op_b;
            3'b101: arith = dec_i.f7_bit ? sra_val : rs1_i >> shamt;
            3'b110: arith = rs1_i | op_b;
            default: arith = rs1_i & op_b;
        endcase

        // the six branch compares
        case (dec_i.funct3)
            3'b000:  cmp = (rs1_i == rs2_i);
            3'b001:  cmp = (rs1_i != rs2_i);
            3'b100:  cmp = ($signed(rs1_i) <  $signed(rs2_i));
            3'b101:  cmp = ($signed(rs1_i) >= $signed(rs2_i));
            3'b110:  cmp = (rs1_i <  rs2_i);
            3'b111:  cmp = (rs1_i >= rs2_i);
            default: cmp = 1'b0;
        endcase

        // effective address, store offset differs from load
        addr_sum = rs1_i + ((dec_i.opcode == `OP_STORE) ? dec_i.imm_s : dec_i.imm_i);
        res_o.mem_addr = addr_sum[`ADDR_W-1:0];

        res_o.taken  = 1'b0;
        res_o.result = arith;
        case (dec_i.opcode)
            `OP_LUI:   res_o.result = dec_i.imm_u;
            `OP_AUIPC: res_o.result = ir_pc + dec_i.imm_u;
            `OP_BRANCH: begin
                res_o.result = ir_pc + dec_i.imm_b;
                res_o.taken  = cmp;
            end
            `OP_JAL: begin
                res_o.result = ir_pc + dec_i.imm_j;
                res_o.taken  = 1'b1;
            end
            `OP_JALR: begin
                res_o.result = (rs1_i + dec_i.imm_i) & ~rv_core_pkg::xword_t'(1);  // clear lsb
                res_o.taken  = 1'b1;
            end
            default: ;
        endcase
    end

endmodule

/* core/rv_decode.sv */
`include "rv_core_settings.svh"

module rv_decode (
    input  rv_core_pkg::inst_t    ir_i,
    output rv_core_pkg::decoded_t dec_o
);

    always_comb begin
        // register and function fields
        dec_o.opcode = ir_i[6:0];
        dec_o.rd     = ir_i[11:7];
        dec_o.rs1    = ir_i[19:15];
        dec_o.rs2    = ir_i[24:20];
        dec_o.funct3 = ir_i[14:12];
        dec_o.f7_bit = ir_i[30];     // also imm[10] of srai
        dec_o.csr    = ir_i[31:20];

        // i-type: loads, jalr, op-imm
        dec_o.imm_i = {{(`XLEN-12){ir_i[31]}}, ir_i[31:20]};

        // s-type: stores, split around rd slot
        dec_o.imm_s = {{(`XLEN-12){ir_i[31]}}, ir_i[31:25], ir_i[11:7]};

        // b-type, 13 bit offset with lsb zero
        dec_o.imm_b = {{(`XLEN-13){ir_i[31]}}, ir_i[31], ir_i[7],
                       ir_i[30:25], ir_i[11:8], 1'b0};

        // j-type, 21 bit offset for jal
        dec_o.imm_j = {{(`XLEN-21){ir_i[31]}}, ir_i[31], ir_i[19:12],
                       ir_i[20], ir_i[30:21], 1'b0};

        // u-type, lui / auipc, sign extended from bit 31 on rv64
        dec_o.imm_u = {{(`XLEN-32){ir_i[31]}}, ir_i[31:12], 12'b0};
    end

endmodule

/* common/rv_core_pkg.sv */
`include "rv_core_settings.svh"

package rv_core_pkg;

    typedef logic [`XLEN-1:0]   xword_t;     // register / data word
    typedef logic [`ILEN-1:0]   inst_t;
    typedef logic [`PC_W-1:0]   pc_t;
    typedef logic [`ADDR_W-1:0] bus_addr_t;
    typedef logic [`REG_AW-1:0] reg_idx_t;
    typedef logic [11:0]        csr_addr_t;
    typedef logic [2:0]         ls_type_t;   // funct3 of the load/store

    // one decode of ir, shared by alu, controller and csr file
    typedef struct packed {
        logic [6:0] opcode;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic [2:0] funct3;
        logic       f7_bit;     // ir[30], sub / sra select
        csr_addr_t  csr;        // ir[31:20], also the mret funct12
        xword_t     imm_i;
        xword_t     imm_s;
        xword_t     imm_b;
        xword_t     imm_j;
        xword_t     imm_u;
    } decoded_t;

    // enable/done bus request, valid for the cycle the enable is high
    typedef struct packed {
        bus_addr_t addr;
        xword_t    wdata;       // low bytes, zero extended
        ls_type_t  ls_type;
        logic      rd_en;
        logic      wr_en;
    } bus_req_t;

    typedef struct packed {
        xword_t    result;      // alu value or redirect target
        logic      taken;       // branch true, or jal / jalr
        bus_addr_t mem_addr;
    } alu_res_t;

    typedef enum logic [1:0] {
        RUN,
        LOAD_WAIT,
        STORE_WAIT
    } ctrl_state_t;

endpackage

/* common/rv_core_settings.svh */
`ifndef RV_CORE_SETTINGS_SVH
`define RV_CORE_SETTINGS_SVH

// widths
`define XLEN        64
`define ILEN        32
`define ADDR_W      39          // sv39 sized bus address
`define PC_W        40
`define REG_AW      5

`define RESET_PC    40'h00_8000_0000    // ram base
`define NOP_WORD    32'h0000_0013       // addi x0, x0, 0

// machine csr addresses
`define CSR_MSTATUS     12'h300
`define CSR_MTVEC       12'h305
`define CSR_MSCRATCH    12'h340
`define CSR_MEPC        12'h341
`define CSR_MCAUSE      12'h342

`define MCAUSE_MEXT     64'h8000_0000_0000_000B   // interrupt flag + cause 11
`define MSTATUS_MIE     3
`define MSTATUS_MPIE    7

// major opcodes
`define OP_LOAD     7'b0000011
`define OP_STORE    7'b0100011
`define OP_BRANCH   7'b1100011
`define OP_JAL      7'b1101111
`define OP_JALR     7'b1100111
`define OP_OPIMM    7'b0010011
`define OP_OP       7'b0110011
`define OP_LUI      7'b0110111
`define OP_AUIPC    7'b0010111
`define OP_SYSTEM   7'b1110011

`endif
